// ==== hw/map_table.sv ====
module map_table #(
    parameter int NUM_SLOTS = rename_pkg::RENAME_WIDTH
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     flush_i,
    input  rename_pkg::commit_slot_t [NUM_SLOTS-1:0] commit_i,
    input  logic [NUM_SLOTS-1:0]                     write_en_i,
    input  rename_pkg::arch_reg_t [NUM_SLOTS-1:0]    write_rd_i,
    input  rename_pkg::phys_reg_t [NUM_SLOTS-1:0]    write_phys_i,
    input  rename_pkg::arch_reg_t [3*NUM_SLOTS-1:0]  read_addr_i,
    output rename_pkg::phys_reg_t [3*NUM_SLOTS-1:0]  read_phys_o
);
    import rename_pkg::*;

    // Current mapping per architectural register
    phys_reg_t map_q [ARCH_REGS];
    // Mapping after this cycle's commits, renames and flush
    phys_reg_t map_d [ARCH_REGS];

    // Register-file identity mapping of an architectural register
    function automatic phys_reg_t identity(input arch_reg_t arch);
        return {1'b0, arch};
    endfunction

    // ==============================
    // Read ports
    // ==============================

    // Three ports per slot: rs1, rs2, then rd for the old destination
    always_comb begin
        for (int p = 0; p < 3 * NUM_SLOTS; p++) begin
            read_phys_o[p] = map_q[read_addr_i[p]];
        end
    end

    // ==============================
    // Next-state
    // ==============================

    always_comb begin
        map_d = map_q;

        // Commits first, each checked against the table before the edge
        // A commit only restores if no younger rename took the register over
        for (int k = 0; k < NUM_SLOTS; k++) begin
            if (commit_i[k].valid && (commit_i[k].arch != '0)) begin
                if (map_q[commit_i[k].arch] == tag_to_phys(commit_i[k].tag)) begin
                    map_d[commit_i[k].arch] = identity(commit_i[k].arch);
                end
            end
        end

        // Renames after commits, so a rename of the same register wins
        // Slot order leaves the youngest write in place
        for (int k = 0; k < NUM_SLOTS; k++) begin
            if (write_en_i[k]) begin
                map_d[write_rd_i[k]] = write_phys_i[k];
            end
        end

        // Flush overrides all of the above
        if (flush_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_d[i] = phys_reg_t'(i);
            end
        end

        // x0 never leaves the zero register
        map_d[0] = '0;
    end

    // ==============================
    // Mapping registers
    // ==============================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Identity: every register starts in the register file
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
        end else begin
            map_q <= map_d;
        end
    end

endmodule

// ==== hw/rename_pkg.sv ====
package rename_pkg;

    // ==============================
    // Sizes
    // ==============================

    // Architectural registers x0..x31
    parameter int ARCH_REGS = 32;
    // Reorder-buffer entries, also the number of rename tags
    parameter int ROB_TAGS = 32;
    // Decode group width
    parameter int RENAME_WIDTH = 3;

    // ==============================
    // Vector types
    // ==============================

    typedef logic [4:0] arch_reg_t;
    // Top bit set means the value lives in the reorder buffer
    typedef logic [5:0] phys_reg_t;
    typedef logic [4:0] rob_tag_t;
    // One bit wider than a tag so that a full ring (32) fits
    typedef logic [5:0] tag_count_t;

    // ==============================
    // Slot structs
    // ==============================

    // One decoded instruction
    typedef struct packed {
        logic      valid;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      rd_we;
    } decode_slot_t;

    // One rename result
    typedef struct packed {
        logic      valid;
        phys_reg_t rs1_phys;
        phys_reg_t rs2_phys;
        phys_reg_t rd_phys;
        phys_reg_t old_rd_phys;
    } rename_slot_t;

    // One commit from the reorder buffer
    typedef struct packed {
        logic      valid;
        arch_reg_t arch;
        rob_tag_t  tag;
    } commit_slot_t;

    // Physical register that stands for a reorder-buffer tag (32 + tag)
    function automatic phys_reg_t tag_to_phys(input rob_tag_t tag);
        return {1'b1, tag};
    endfunction

endpackage

// ==== hw/rename_unit.sv ====
module rename_unit #(
    parameter int NUM_SLOTS = rename_pkg::RENAME_WIDTH
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     flush_i,
    input  rename_pkg::decode_slot_t [NUM_SLOTS-1:0] decode_i,
    input  rename_pkg::commit_slot_t [NUM_SLOTS-1:0] commit_i,
    output rename_pkg::rename_slot_t [NUM_SLOTS-1:0] rename_o,
    output logic [NUM_SLOTS-1:0]                     rename_ready_o
);
    import rename_pkg::*;

    // Ring side
    logic [NUM_SLOTS-1:0]     alloc_req;
    logic [NUM_SLOTS-1:0]     tag_free;
    logic [NUM_SLOTS-1:0]     grant;
    rob_tag_t [NUM_SLOTS-1:0] grant_tag;

    // Table side
    logic [NUM_SLOTS-1:0]        write_en;
    arch_reg_t [NUM_SLOTS-1:0]   write_rd;
    phys_reg_t [NUM_SLOTS-1:0]   write_phys;
    arch_reg_t [3*NUM_SLOTS-1:0] table_addr;
    phys_reg_t [3*NUM_SLOTS-1:0] table_phys;

    // ==============================
    // Slot field breakout
    // ==============================

    // Every valid decode slot asks for a tag, every valid commit returns one
    // The new mapping written is the slot's own rd_phys
    always_comb begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            alloc_req[k]  = decode_i[k].valid;
            tag_free[k]   = commit_i[k].valid;
            write_rd[k]   = decode_i[k].rd;
            write_phys[k] = rename_o[k].rd_phys;
        end
    end

    tag_ring #(
        .NUM_SLOTS(NUM_SLOTS)
    ) u_ring (
        .clk        (clk),
        .reset      (reset),
        .flush_i    (flush_i),
        .alloc_req_i(alloc_req),
        .free_i     (tag_free),
        .grant_o    (grant),
        .grant_tag_o(grant_tag),
        .ready_o    (rename_ready_o)
    );

    map_table #(
        .NUM_SLOTS(NUM_SLOTS)
    ) u_table (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .commit_i    (commit_i),
        .write_en_i  (write_en),
        .write_rd_i  (write_rd),
        .write_phys_i(write_phys),
        .read_addr_i (table_addr),
        .read_phys_o (table_phys)
    );

    source_lookup #(
        .NUM_SLOTS(NUM_SLOTS)
    ) u_lookup (
        .decode_i    (decode_i),
        .grant_i     (grant),
        .grant_tag_i (grant_tag),
        .table_phys_i(table_phys),
        .table_addr_o(table_addr),
        .write_en_o  (write_en),
        .rename_o    (rename_o)
    );

endmodule

// ==== hw/source_lookup.sv ====
module source_lookup #(
    parameter int NUM_SLOTS = rename_pkg::RENAME_WIDTH
) (
    input  rename_pkg::decode_slot_t [NUM_SLOTS-1:0]  decode_i,
    input  logic [NUM_SLOTS-1:0]                      grant_i,
    input  rename_pkg::rob_tag_t [NUM_SLOTS-1:0]      grant_tag_i,
    input  rename_pkg::phys_reg_t [3*NUM_SLOTS-1:0]   table_phys_i,
    output rename_pkg::arch_reg_t [3*NUM_SLOTS-1:0]   table_addr_o,
    output logic [NUM_SLOTS-1:0]                      write_en_o,
    output rename_pkg::rename_slot_t [NUM_SLOTS-1:0]  rename_o
);
    import rename_pkg::*;

    // Destination physical register of each slot, from its tag
    phys_reg_t [NUM_SLOTS-1:0] new_phys;

    // Youngest earlier slot writing addr supplies the mapping, else the table
    function automatic phys_reg_t bypass(
        input arch_reg_t                 addr,
        input phys_reg_t                 table_val,
        input int                        slot,
        input logic [NUM_SLOTS-1:0]      wen,
        input decode_slot_t [NUM_SLOTS-1:0] dec,
        input phys_reg_t [NUM_SLOTS-1:0] fresh
    );
        phys_reg_t result;
        result = table_val;
        // Later hits overwrite earlier ones, so the youngest wins
        for (int j = 0; j < slot; j++) begin
            if (wen[j] && (dec[j].rd == addr)) begin
                result = fresh[j];
            end
        end
        return result;
    endfunction

    // ==============================
    // Table addresses and writes
    // ==============================

    always_comb begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            table_addr_o[3*k]     = decode_i[k].rs1;
            table_addr_o[3*k + 1] = decode_i[k].rs2;
            table_addr_o[3*k + 2] = decode_i[k].rd;
            new_phys[k]           = tag_to_phys(grant_tag_i[k]);
            // x0 and non-writing slots hold a tag but never enter the table
            write_en_o[k] = grant_i[k] && decode_i[k].rd_we && (decode_i[k].rd != '0);
        end
    end

    // ==============================
    // Rename results
    // ==============================

    always_comb begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            rename_o[k].valid    = grant_i[k];
            rename_o[k].rs1_phys = bypass(decode_i[k].rs1, table_phys_i[3*k], k,
                                          write_en_o, decode_i, new_phys);
            rename_o[k].rs2_phys = bypass(decode_i[k].rs2, table_phys_i[3*k + 1], k,
                                          write_en_o, decode_i, new_phys);
            if (grant_i[k]) begin
                rename_o[k].rd_phys     = new_phys[k];
                rename_o[k].old_rd_phys = bypass(decode_i[k].rd, table_phys_i[3*k + 2], k,
                                                 write_en_o, decode_i, new_phys);
            end else begin
                // Back-pressured slot carries no destination
                rename_o[k].rd_phys     = '0;
                rename_o[k].old_rd_phys = '0;
            end
        end
    end

endmodule

// ==== hw/tag_ring.sv ====
module tag_ring #(
    parameter int NUM_SLOTS = rename_pkg::RENAME_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 flush_i,
    input  logic [NUM_SLOTS-1:0]                 alloc_req_i,
    input  logic [NUM_SLOTS-1:0]                 free_i,
    output logic [NUM_SLOTS-1:0]                 grant_o,
    output rename_pkg::rob_tag_t [NUM_SLOTS-1:0] grant_tag_o,
    output logic [NUM_SLOTS-1:0]                 ready_o
);
    import rename_pkg::*;

    // Next tag to hand out
    rob_tag_t   head_q;
    // Tags still free to hand out
    tag_count_t free_cnt_q;

    tag_count_t grant_cnt;
    tag_count_t return_cnt;

    // ==============================
    // Grant
    // ==============================

    // Slot k wins if enough tags remain for every requester ahead of it
    // Grants are therefore a prefix of the request slots
    always_comb begin
        tag_count_t reqs_ahead;
        tag_count_t grants_ahead;
        reqs_ahead   = '0;
        grants_ahead = '0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            grant_o[k] = alloc_req_i[k] && (free_cnt_q > reqs_ahead);
            // Tags leave in order, so offset from head by earlier grants
            grant_tag_o[k] = head_q + rob_tag_t'(grants_ahead);
            reqs_ahead   = reqs_ahead + tag_count_t'(alloc_req_i[k]);
            grants_ahead = grants_ahead + tag_count_t'(grant_o[k]);
        end
    end

    // Thermometer ready where bit k means k+1 tags available
    always_comb begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            ready_o[k] = free_cnt_q > tag_count_t'(k);
        end
    end

    // Number of tags taken and given back this cycle
    always_comb begin
        grant_cnt  = '0;
        return_cnt = '0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            grant_cnt  = grant_cnt + tag_count_t'(grant_o[k]);
            return_cnt = return_cnt + tag_count_t'(free_i[k]);
        end
    end

    // ==============================
    // Pointer and count update
    // ==============================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_q     <= '0;
            free_cnt_q <= tag_count_t'(ROB_TAGS);
        end else if (flush_i) begin
            // Everything in flight is discarded and the ring is empty again
            head_q     <= '0;
            free_cnt_q <= tag_count_t'(ROB_TAGS);
        end else begin
            // Head wraps modulo 32 through the 5-bit tag width
            head_q     <= head_q + rob_tag_t'(grant_cnt);
            free_cnt_q <= free_cnt_q - grant_cnt + return_cnt;
        end
    end

endmodule

// ==== rename_unit.f ====
hw/rename_pkg.sv
hw/tag_ring.sv
hw/map_table.sv
hw/source_lookup.sv
hw/rename_unit.sv
tb/rename_properties.sv
tb/rename_checker.sv
tb/rename_tb.sv

// ==== tb/rename_checker.sv ====
module rename_checker #(
    parameter int NUM_SLOTS = rename_pkg::RENAME_WIDTH
) (
    input  logic                                     clk,
    input  logic                                     check_en_i,
    input  int                                       row_i,
    input  rename_pkg::rename_slot_t [NUM_SLOTS-1:0] exp_rename_i,
    input  logic [NUM_SLOTS-1:0]                     exp_ready_i,
    input  rename_pkg::rename_slot_t [NUM_SLOTS-1:0] rename_i,
    input  logic [NUM_SLOTS-1:0]                     ready_i,
    output int                                       rows_checked_o,
    output int                                       errors_o
);
    import rename_pkg::*;

    int checked = 0;
    int errors = 0;
    int row_errors;

    assign rows_checked_o = checked;
    assign errors_o       = errors;

    // One field against its expected value, named as the DUT port
    task automatic compare_field(input string name, input phys_reg_t got, input phys_reg_t exp);
        if (got !== exp) begin
            $display("[FAIL] row %0d %s: got 0x%0h expected 0x%0h", row_i, name, got, exp);
            row_errors++;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (check_en_i) begin
            row_errors = 0;
            for (int k = 0; k < NUM_SLOTS; k++) begin
                compare_field($sformatf("rename_o[%0d].valid", k),
                              phys_reg_t'(rename_i[k].valid), phys_reg_t'(exp_rename_i[k].valid));
                compare_field($sformatf("rename_o[%0d].rs1_phys", k),
                              rename_i[k].rs1_phys, exp_rename_i[k].rs1_phys);
                compare_field($sformatf("rename_o[%0d].rs2_phys", k),
                              rename_i[k].rs2_phys, exp_rename_i[k].rs2_phys);
                compare_field($sformatf("rename_o[%0d].rd_phys", k),
                              rename_i[k].rd_phys, exp_rename_i[k].rd_phys);
                compare_field($sformatf("rename_o[%0d].old_rd_phys", k),
                              rename_i[k].old_rd_phys, exp_rename_i[k].old_rd_phys);
            end
            compare_field("rename_ready_o", phys_reg_t'(ready_i), phys_reg_t'(exp_ready_i));
            if (row_errors == 0) begin
                $display("row %0d: pass", row_i);
            end else begin
                $display("row %0d: %0d mismatches", row_i, row_errors);
            end
            errors  += row_errors;
            checked += 1;
        end
    end

endmodule

// ==== tb/rename_properties.sv ====
module rename_properties #(
    parameter int NUM_SLOTS = rename_pkg::RENAME_WIDTH
) (
    input logic                   clk,
    input logic                   reset,
    input rename_pkg::tag_count_t free_cnt_i,
    input logic [NUM_SLOTS-1:0]   grant_i,
    input rename_pkg::phys_reg_t  zero_map_i
);
    import rename_pkg::*;

    // Running total of failed properties, read by the testbench at the end
    int assert_failures = 0;

    // x0 stays on the zero register
    zero_entry: assert property (@(posedge clk) disable iff (!reset) zero_map_i == '0)
        else begin
            $error("map entry 0 holds 0x%0h", zero_map_i);
            assert_failures++;
        end

    // Ring never holds more free tags than it has
    count_bound: assert property (@(posedge clk) disable iff (!reset)
        free_cnt_i <= tag_count_t'(ROB_TAGS))
        else begin
            $error("free count 0x%0h above ring size", free_cnt_i);
            assert_failures++;
        end

    // Empty ring grants nothing
    no_grant_empty: assert property (@(posedge clk) disable iff (!reset)
        (free_cnt_i == '0) |-> (grant_i == '0))
        else begin
            $error("grant 0x%0h with no free tag", grant_i);
            assert_failures++;
        end

endmodule

// Ring count and table entry 0 reached from the DUT top
bind rename_unit rename_properties #(.NUM_SLOTS(NUM_SLOTS)) u_props (
    .clk       (clk),
    .reset     (reset),
    .free_cnt_i(u_ring.free_cnt_q),
    .grant_i   (grant),
    .zero_map_i(u_table.map_q[0])
);

// ==== tb/rename_tb.sv ====
module rename_tb;
    import rename_pkg::*;

    localparam int NUM_SLOTS = RENAME_WIDTH;
    localparam int MAX_ROWS = 32;

    logic                         clk;
    logic                         reset;
    logic                         flush;
    decode_slot_t [NUM_SLOTS-1:0] decode;
    commit_slot_t [NUM_SLOTS-1:0] commit;
    rename_slot_t [NUM_SLOTS-1:0] renamed;
    logic [NUM_SLOTS-1:0]         rename_ready;

    // Expected values of the row in flight, for the checker
    logic                         check_en;
    int                           row_idx;
    rename_slot_t [NUM_SLOTS-1:0] exp_rename;
    logic [NUM_SLOTS-1:0]         exp_ready;
    int                           rows_checked;
    int                           check_errors;

    // ==============================
    // Stimulus table, one row per cycle
    decode_slot_t [NUM_SLOTS-1:0] dec_tab [MAX_ROWS];
    commit_slot_t [NUM_SLOTS-1:0] com_tab [MAX_ROWS];
    rename_slot_t [NUM_SLOTS-1:0] exp_tab [MAX_ROWS];
    logic [NUM_SLOTS-1:0]         ready_tab [MAX_ROWS];
    logic                         flush_tab [MAX_ROWS];
    int                           num_rows = 0;
    bit                           table_built = 1'b0;

    function automatic decode_slot_t instr(input logic v, input arch_reg_t rs1, rs2, rd,
                                           input logic we);
        return '{v, rs1, rs2, rd, we};
    endfunction

    function automatic rename_slot_t res(input logic v, input phys_reg_t rs1, rs2, rd, old);
        return '{v, rs1, rs2, rd, old};
    endfunction

    function automatic commit_slot_t retire(input arch_reg_t arch, input rob_tag_t tag);
        return '{1'b1, arch, tag};
    endfunction

    // New row, slot 0 lowest, no commit and no flush unless set after
    task automatic load_group(input decode_slot_t d0, d1, d2);
        dec_tab[num_rows]   = {d2, d1, d0};
        com_tab[num_rows]   = '0;
        flush_tab[num_rows] = 1'b0;
    endtask

    task automatic retire_group(input commit_slot_t c0, c1, c2);
        com_tab[num_rows] = {c2, c1, c0};
    endtask

    task automatic expect_out(input rename_slot_t r0, r1, r2, input logic [2:0] ready);
        exp_tab[num_rows]   = {r2, r1, r0};
        ready_tab[num_rows] = ready;
        num_rows++;
    endtask

    // Tag-only groups on x0, they take tags but never touch the table
    task automatic drain_rows(input int count, input int first_tag);
        int tag;
        tag = first_tag;
        for (int i = 0; i < count; i++) begin
            load_group(instr(1, 0, 0, 0, 0), instr(1, 0, 0, 0, 0), instr(1, 0, 0, 0, 0));
            expect_out(res(1, 0, 0, phys_reg_t'(32 + tag % 32), 0),
                       res(1, 0, 0, phys_reg_t'(32 + (tag + 1) % 32), 0),
                       res(1, 0, 0, phys_reg_t'(32 + (tag + 2) % 32), 0), 3'b111);
            tag += 3;
        end
    endtask

    task automatic build_table();
        // Fresh table, tags 0..2
        load_group(instr(1, 1, 2, 7, 1), instr(1, 3, 4, 8, 1), instr(1, 5, 6, 9, 1));
        expect_out(res(1, 1, 2, 32, 7), res(1, 3, 4, 33, 8), res(1, 5, 6, 34, 9), 3'b111);
        // In-group bypass, youngest writer wins, x0 not forwarded
        load_group(instr(1, 1, 2, 10, 1), instr(1, 10, 0, 10, 1), instr(1, 10, 11, 0, 1));
        expect_out(res(1, 1, 2, 35, 10), res(1, 35, 0, 36, 35), res(1, 36, 11, 37, 0),
                   3'b111);
        // rd_we clear not forwarded, earlier mappings persist
        load_group(instr(1, 12, 0, 0, 1), instr(1, 0, 10, 12, 0), instr(1, 12, 7, 8, 1));
        expect_out(res(1, 12, 0, 38, 0), res(1, 0, 36, 39, 12), res(1, 12, 32, 40, 33),
                   3'b111);
        // Commit tags 0..2, tag 1 already superseded on x8
        load_group('0, '0, '0);
        retire_group(retire(7, 0), retire(8, 1), retire(9, 2));
        expect_out('0, '0, '0, 3'b111);
        load_group(instr(1, 7, 8, 9, 1), instr(1, 9, 10, 0, 0), '0);
        retire_group(retire(10, 3), '0, '0);
        expect_out(res(1, 7, 40, 41, 9), res(1, 41, 36, 42, 0), '0, 3'b111);
        // 24 more tags, head wraps to 3 and one tag is left
        drain_rows(8, 11);
        load_group(instr(1, 9, 7, 11, 1), instr(1, 0, 0, 5, 1), instr(1, 0, 0, 5, 1));
        expect_out(res(1, 41, 7, 35, 11), '0, '0, 3'b001);
        load_group(instr(1, 5, 11, 6, 1), '0, '0);
        retire_group(retire(10, 4), retire(0, 5), retire(0, 6));
        expect_out(res(0, 5, 35, 0, 0), '0, '0, 3'b000);
        // Returned tags 4..6 handed out again
        load_group(instr(1, 10, 9, 9, 1), instr(1, 9, 5, 21, 0), instr(1, 11, 0, 22, 1));
        expect_out(res(1, 10, 41, 36, 41), res(1, 36, 5, 37, 21), res(1, 35, 0, 38, 22),
                   3'b111);
        load_group('0, '0, '0);
        flush_tab[num_rows] = 1'b1;
        expect_out('0, '0, '0, 3'b000);
        // Identity again, first tag is 0
        load_group(instr(1, 9, 22, 11, 1), instr(1, 11, 7, 7, 1), '0);
        expect_out(res(1, 9, 22, 32, 11), res(1, 32, 7, 33, 7), '0, 3'b111);
    endtask

    // ==============================
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        int total;
        reset      = 1'b0;
        flush      = 1'b0;
        decode     = '0;
        commit     = '0;
        check_en   = 1'b0;
        row_idx    = 0;
        exp_rename = '0;
        exp_ready  = '0;
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b1;
        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            #1;
            decode     = dec_tab[r];
            commit     = com_tab[r];
            flush      = flush_tab[r];
            exp_rename = exp_tab[r];
            exp_ready  = ready_tab[r];
            row_idx    = r;
            check_en   = 1'b1;
        end
        wait (rows_checked == num_rows);
        total = check_errors + u_dut.u_props.assert_failures;
        $display("%0d rows checked, %0d errors", rows_checked, total);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the row count
    initial begin
        wait (table_built);
        #(num_rows * 4 + 40);
        $display("Timeout: not every row was checked in time");
        $display("Simulation failed");
        $finish;
    end

    rename_unit #(.NUM_SLOTS(NUM_SLOTS)) u_dut (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush),
        .decode_i      (decode),
        .commit_i      (commit),
        .rename_o      (renamed),
        .rename_ready_o(rename_ready)
    );

    rename_checker #(.NUM_SLOTS(NUM_SLOTS)) u_checker (
        .clk           (clk),
        .check_en_i    (check_en),
        .row_i         (row_idx),
        .exp_rename_i  (exp_rename),
        .exp_ready_i   (exp_ready),
        .rename_i      (renamed),
        .ready_i       (rename_ready),
        .rows_checked_o(rows_checked),
        .errors_o      (check_errors)
    );

endmodule
